// File: Makefile
# Verilator build and run for the Ethernet glue testbench

VERILATOR ?= verilator
TB_TOP    ?= eth_glue_tb
RTL_TOP   ?= eth_glue_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
verilog/eth_glue_pkg.sv
verilog/heartbeat_led.sv
verilog/udp_tx_engine.sv
verilog/tx_arbiter.sv
verilog/rx_frame_buffer.sv
verilog/eth_glue_top.sv
tests/eth_glue_assertions.sv
tests/eth_glue_tb.sv

// File: tests/eth_glue_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module eth_glue_assertions
    import eth_glue_pkg::*;
#(
    parameter int RX_CREDITS = 4
) (
    input wire   HCLK,
    input wire   rst_key,
    input wire   tstart_i,
    input wire   taccept_i,
    input byte_t mac_tdata_i,
    input wire   mac_tlast_i,
    input byte_t cpu_tdata_i,
    input wire   cpu_tvalid_i,
    input wire   cpu_tlast_i,
    input wire   cpu_tready_i,
    input byte_t udp_tdata_i,
    input wire   udp_tvalid_i,
    input wire   udp_tlast_i,
    input wire   udp_tready_i,
    input wire   rx_valid_i,
    input wire   rx_credit_i
);

    int credit_model;    // credits the host has granted and not yet seen used

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            credit_model <= RX_CREDITS;
        end else begin
            credit_model <= credit_model - int'(rx_valid_i) + int'(rx_credit_i);
        end
    end

    // start marks only the first byte of a frame
    start_once: assert property (@(posedge HCLK) disable iff (!rst_key)
        (tstart_i && taccept_i) |=> !tstart_i)
        else $error("mac_tstart_o high again after an accepted start byte");

    // a source sees tready only while its own byte goes out to the MAC
    cpu_muted: assert property (@(posedge HCLK) disable iff (!rst_key)
        (cpu_tready_i && cpu_tvalid_i) |->
            (taccept_i && mac_tdata_i == cpu_tdata_i && mac_tlast_i == cpu_tlast_i))
        else $error("cpu_tready_o high while the CPU byte is not on the MAC port");

    udp_muted: assert property (@(posedge HCLK) disable iff (!rst_key)
        (udp_tready_i && udp_tvalid_i) |->
            (taccept_i && mac_tdata_i == udp_tdata_i && mac_tlast_i == udp_tlast_i))
        else $error("udp_tready_o high while the UDP byte is not on the MAC port");

    // host never sees an entry it has no credit for
    rx_credit_guard: assert property (@(posedge HCLK) disable iff (!rst_key)
        (credit_model == 0) |-> !rx_valid_i)
        else $error("rx_valid_o high with zero credits");

endmodule

`default_nettype wire

// File: tests/eth_glue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_glue_tb
    import eth_glue_pkg::*;
();

    localparam int HB_TICKS   = 20;
    localparam int RX_DEPTH   = 16;
    localparam int RX_CREDITS = 4;
    localparam int TIMEOUT    = 400;        // cycles allowed per wait

    logic       HCLK = 1'b0;
    logic       rst_key;
    logic       hsel_i;
    ahb_word_t  haddr_i;
    logic [1:0] htrans_i;
    logic       hwrite_i;
    logic       hready_i;
    ahb_word_t  hwdata_i;
    ahb_word_t  hrdata_o;
    logic       hreadyout_o;
    logic       hresp_o;
    byte_t      cpu_tdata_i;
    logic       cpu_tvalid_i;
    logic       cpu_tlast_i;
    logic       cpu_tready_o;
    byte_t      mac_tdata_o;
    logic       mac_tstart_o;
    logic       mac_tlast_o;
    logic       mac_tpnd_i = 1'b0;
    byte_t      mac_rdata_i;
    logic       mac_rvalid_i;
    logic       mac_rlast_i;
    logic       rx_valid_o;
    byte_t      rx_data_o;
    logic       rx_last_o;
    logic       rx_credit_i;
    logic [7:0] rx_drop_count_o;
    logic       led_o;

    logic [31:0] lfsr = 32'h95232470;
    bit          in_frame = 1'b0;           // MAC is inside a frame
    logic [9:0]  mac_q [$];                 // {start, last, data}
    logic [8:0]  rx_q [$];                  // {last, data}
    int          value_errs = 0;
    int          other_errs = 0;

    eth_glue_top #(
        .HEARTBEAT_TICKS (27'(HB_TICKS)),
        .RX_DEPTH        (RX_DEPTH),
        .RX_CREDITS      (RX_CREDITS)
    ) DUT (
        .HCLK            (HCLK),
        .rst_key         (rst_key),
        .hsel_i          (hsel_i),
        .haddr_i         (haddr_i),
        .htrans_i        (htrans_i),
        .hwrite_i        (hwrite_i),
        .hready_i        (hready_i),
        .hwdata_i        (hwdata_i),
        .hrdata_o        (hrdata_o),
        .hreadyout_o     (hreadyout_o),
        .hresp_o         (hresp_o),
        .cpu_tdata_i     (cpu_tdata_i),
        .cpu_tvalid_i    (cpu_tvalid_i),
        .cpu_tlast_i     (cpu_tlast_i),
        .cpu_tready_o    (cpu_tready_o),
        .mac_tdata_o     (mac_tdata_o),
        .mac_tstart_o    (mac_tstart_o),
        .mac_tlast_o     (mac_tlast_o),
        .mac_tpnd_i      (mac_tpnd_i),
        .mac_rdata_i     (mac_rdata_i),
        .mac_rvalid_i    (mac_rvalid_i),
        .mac_rlast_i     (mac_rlast_i),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o),
        .rx_last_o       (rx_last_o),
        .rx_credit_i     (rx_credit_i),
        .rx_drop_count_o (rx_drop_count_o),
        .led_o           (led_o)
    );

    bind tx_arbiter eth_glue_assertions u_arb_checks (
        .HCLK         (HCLK),
        .rst_key      (rst_key),
        .tstart_i     (mac_tstart_o),
        .taccept_i    (accept),
        .mac_tdata_i  (mac_tdata_o),
        .mac_tlast_i  (mac_tlast_o),
        .cpu_tdata_i  (cpu_tdata_i),
        .cpu_tvalid_i (cpu_tvalid_i),
        .cpu_tlast_i  (cpu_tlast_i),
        .cpu_tready_i (cpu_tready_o),
        .udp_tdata_i  (udp_tdata_i),
        .udp_tvalid_i (udp_tvalid_i),
        .udp_tlast_i  (udp_tlast_i),
        .udp_tready_i (udp_tready_o),
        .rx_valid_i   (1'b0),
        .rx_credit_i  (1'b0)
    );

    bind rx_frame_buffer eth_glue_assertions #(
        .RX_CREDITS (RX_CREDITS)
    ) u_rx_checks (
        .HCLK         (HCLK),
        .rst_key      (rst_key),
        .tstart_i     (1'b0),
        .taccept_i    (1'b0),
        .mac_tdata_i  (8'h00),
        .mac_tlast_i  (1'b0),
        .cpu_tdata_i  (8'h00),
        .cpu_tvalid_i (1'b0),
        .cpu_tlast_i  (1'b0),
        .cpu_tready_i (1'b0),
        .udp_tdata_i  (8'h00),
        .udp_tvalid_i (1'b0),
        .udp_tlast_i  (1'b0),
        .udp_tready_i (1'b0),
        .rx_valid_i   (rx_valid_o),
        .rx_credit_i  (rx_credit_i)
    );

    always #5 HCLK = ~HCLK;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(negedge HCLK) begin
        if (rst_key) begin
            lfsr = lfsr_step(lfsr);
            mac_tpnd_i = lfsr[0];           // one bit per cycle
        end
    end

    // MAC transmit side takes a byte on every pending cycle of a frame
    always @(posedge HCLK) begin
        if (rst_key && mac_tpnd_i && (in_frame || mac_tstart_o)) begin
            mac_q.push_back({mac_tstart_o, mac_tlast_o, mac_tdata_o});
            in_frame = !mac_tlast_o;
        end
    end

    always @(posedge HCLK) begin
        if (rst_key && rx_valid_o) begin
            rx_q.push_back({rx_last_o, rx_data_o});   // host side
        end
    end

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error [%s] expected 8'h%02h, actual 8'h%02h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input frame_len_t exp, input frame_len_t act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error [%s] expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input ahb_word_t exp, input ahb_word_t act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error [%s] expected 32'h%08h, actual 32'h%08h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error [%s] expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic int entry_count(input bit rx_side);
        return rx_side ? rx_q.size() : mac_q.size();
    endfunction

    task automatic wait_entries(input string what, input bit rx_side, input int target);
        int waited;
        waited = 0;
        while (entry_count(rx_side) < target && waited < TIMEOUT) begin
            @(negedge HCLK);
            waited++;
        end
        if (entry_count(rx_side) < target) begin
            other_errs++;
            $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
        end
    endtask

    task automatic wait_led_toggle(output int cycles);
        logic prev;
        prev = led_o;
        cycles = 0;
        while (led_o === prev && cycles < TIMEOUT) begin
            @(negedge HCLK);
            cycles++;
        end
        if (led_o === prev) begin
            other_errs++;
            $display("Timeout: led_o did not toggle within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic ahb_write(input udp_reg_e reg_off, input ahb_word_t data);
        @(negedge HCLK);
        hsel_i   = 1'b1;
        haddr_i  = {UDP_REGION, 24'd0, reg_off};
        htrans_i = HTRANS_NONSEQ;
        hwrite_i = 1'b1;
        @(negedge HCLK);
        hsel_i   = 1'b0;                    // data phase
        htrans_i = 2'b00;
        hwrite_i = 1'b0;
        hwdata_i = data;
    endtask

    task automatic ahb_read(input udp_reg_e reg_off, output ahb_word_t data);
        @(negedge HCLK);
        hsel_i   = 1'b1;
        haddr_i  = {UDP_REGION, 24'd0, reg_off};
        htrans_i = HTRANS_NONSEQ;
        hwrite_i = 1'b0;
        @(negedge HCLK);
        data = hrdata_o;
        check_bit("ahb hreadyout", 1'b1, hreadyout_o);
        check_bit("ahb hresp", 1'b0, hresp_o);
        hsel_i   = 1'b0;
        htrans_i = 2'b00;
    endtask

    task automatic send_cpu_frame(input byte_t bytes [3]);
        int idx;
        int waited;
        idx = 0;
        waited = 0;
        while (idx < 3 && waited < TIMEOUT) begin
            @(negedge HCLK);
            cpu_tvalid_i = 1'b1;
            cpu_tdata_i  = bytes[idx];
            cpu_tlast_i  = (idx == 2);
            @(posedge HCLK);
            if (cpu_tready_o) begin
                idx++;                      // byte taken on this edge
            end
            waited++;
        end
        @(negedge HCLK);
        cpu_tvalid_i = 1'b0;
        cpu_tlast_i  = 1'b0;
        if (idx < 3) begin
            other_errs++;
            $display("Timeout: CPU frame stalled after %0d bytes", idx);
        end
    endtask

    task automatic inject_rx(input byte_t first, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge HCLK);
            mac_rvalid_i = 1'b1;
            mac_rdata_i  = first + 8'(i);
            mac_rlast_i  = (i == n - 1);
        end
        @(negedge HCLK);
        mac_rvalid_i = 1'b0;
        mac_rlast_i  = 1'b0;
    endtask

    task automatic pulse_credits(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge HCLK);
            rx_credit_i = 1'b1;
            @(negedge HCLK);
            rx_credit_i = 1'b0;
        end
    endtask

    task automatic check_mac_entry(input string test, input int base, input int i,
                                   input byte_t data, input logic start, input logic last);
        string tag;
        tag = $sformatf("%s byte %0d", test, i);
        check_byte({tag, " data"}, data, mac_q[base + i][7:0]);
        check_bit({tag, " start"}, start, mac_q[base + i][9]);
        check_bit({tag, " last"}, last, mac_q[base + i][8]);
    endtask

    task automatic test_reset_state();
        check_bit("reset mac_tstart_o", 1'b0, mac_tstart_o);
        check_bit("reset rx_valid_o", 1'b0, rx_valid_o);
        check_bit("reset cpu_tready_o", 1'b0, cpu_tready_o);
        check_bit("reset led_o", 1'b1, led_o);
    endtask

    task automatic test_heartbeat();
        int cycles;
        check_bit("heartbeat start", 1'b1, led_o);
        wait_led_toggle(cycles);
        check_bit("heartbeat first toggle", 1'b0, led_o);
        check_word("heartbeat first period", HB_TICKS + 1, cycles);
        wait_led_toggle(cycles);
        check_word("heartbeat period", HB_TICKS + 1, cycles);
    endtask

    task automatic test_udp_frame();
        ahb_word_t rd;
        byte_t     exp;
        int        base;
        ahb_read(REG_STATUS, rd);
        check_word("udp_frame idle status", 32'h0, rd);
        base = mac_q.size();
        ahb_write(REG_SEED, 32'h0000_00FE);
        ahb_write(REG_LEN, 32'd5);
        ahb_read(REG_LEN, rd);
        check_len("udp_frame len readback", 11'd5, rd[10:0]);
        ahb_write(REG_CTRL, 32'd1);
        wait_entries("udp_frame bytes", 1'b0, base + 5);
        exp = 8'hFE;
        for (int i = 0; i < 5; i++) begin
            check_mac_entry("udp_frame", base, i, exp, i == 0, i == 4);
            exp = exp + 8'd1;               // counting bytes wrap at 256
        end
        ahb_read(REG_STATUS, rd);
        check_word("udp_frame done status", {16'd1, 15'd0, 1'b0}, rd);
    endtask

    task automatic test_cpu_frame();
        byte_t bytes [3];
        int    base;
        bytes = '{8'hA5, 8'h3C, 8'h7E};
        base = mac_q.size();
        send_cpu_frame(bytes);
        wait_entries("cpu_frame bytes", 1'b0, base + 3);
        for (int i = 0; i < 3; i++) begin
            check_mac_entry("cpu_frame", base, i, bytes[i], i == 0, i == 2);
        end
    endtask

    task automatic test_arbitration();
        byte_t     bytes [3];
        byte_t     exp;
        ahb_word_t rd;
        int        base;
        bytes = '{8'hC1, 8'hC2, 8'hC3};
        base = mac_q.size();
        ahb_write(REG_SEED, 32'h0000_0040);
        ahb_write(REG_LEN, 32'd4);
        ahb_write(REG_CTRL, 32'd1);
        send_cpu_frame(bytes);              // valid in the same idle cycle as udp
        wait_entries("arbitration bytes", 1'b0, base + 7);
        exp = 8'h40;
        for (int i = 0; i < 4; i++) begin
            check_mac_entry("arbitration udp", base, i, exp, i == 0, i == 3);
            exp = exp + 8'd1;
        end
        for (int i = 0; i < 3; i++) begin
            check_mac_entry("arbitration cpu", base + 4, i, bytes[i], i == 0, i == 2);
        end
        ahb_read(REG_STATUS, rd);
        check_word("arbitration status", {16'd2, 15'd0, 1'b0}, rd);
    endtask

    task automatic test_rx_credits();
        int base;
        base = rx_q.size();
        inject_rx(8'h30, 6);
        wait_entries("rx_credits first entries", 1'b1, base + RX_CREDITS);
        repeat (20) @(negedge HCLK);       // quiet window, nothing else may leave
        check_len("rx_credits held back", frame_len_t'(RX_CREDITS),
                  frame_len_t'(rx_q.size() - base));
        pulse_credits(2);
        wait_entries("rx_credits remaining entries", 1'b1, base + 6);
        for (int i = 0; i < 6; i++) begin
            check_byte($sformatf("rx_credits entry %0d data", i), 8'h30 + 8'(i),
                       rx_q[base + i][7:0]);
            check_bit($sformatf("rx_credits entry %0d last", i), i == 5, rx_q[base + i][8]);
        end
    endtask

    task automatic test_overflow();
        int base;
        base = rx_q.size();
        inject_rx(8'h60, 20);               // no credits left from the last test
        check_byte("overflow drop count", byte_t'(20 - RX_DEPTH), rx_drop_count_o);
        check_len("overflow emitted", 11'd0, frame_len_t'(rx_q.size() - base));
    endtask

    initial begin
        rst_key      = 1'b0;
        hsel_i       = 1'b0;
        haddr_i      = '0;
        htrans_i     = 2'b00;
        hwrite_i     = 1'b0;
        hready_i     = 1'b1;
        hwdata_i     = '0;
        cpu_tdata_i  = '0;
        cpu_tvalid_i = 1'b0;
        cpu_tlast_i  = 1'b0;
        mac_rdata_i  = '0;
        mac_rvalid_i = 1'b0;
        mac_rlast_i  = 1'b0;
        rx_credit_i  = 1'b0;
        repeat (16) @(negedge HCLK);
        test_reset_state();
        rst_key = 1'b1;
        test_heartbeat();
        test_udp_frame();
        test_cpu_frame();
        test_arbitration();
        test_rx_credits();
        test_overflow();
        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/eth_glue_pkg.sv
`default_nettype none

package eth_glue_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [10:0] frame_len_t;      // 0 means no frame
    typedef logic [9:0]  rx_entry_t;       // {last, valid, data}
    typedef logic [31:0] ahb_word_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_CPU  = 2'd1,
        ARB_UDP  = 2'd2
    } arb_state_e;

    typedef enum logic {
        UDP_IDLE = 1'b0,
        UDP_SEND = 1'b1
    } udp_state_e;

    // register offsets within the engine region, haddr[3:0]
    typedef enum logic [3:0] {
        REG_LEN    = 4'h0,
        REG_CTRL   = 4'h4,
        REG_SEED   = 4'h8,
        REG_STATUS = 4'hC
    } udp_reg_e;

    localparam logic [3:0] UDP_REGION    = 4'h7;   // haddr[31:28]
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

endpackage

`default_nettype wire

// File: verilog/eth_glue_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_glue_top
    import eth_glue_pkg::*;
#(
    parameter logic [26:0] HEARTBEAT_TICKS = 27'd33000000,
    parameter int          RX_DEPTH        = 16,
    parameter int          RX_CREDITS      = 4
) (
    input  wire        HCLK,
    input  wire        rst_key,
    input  wire        hsel_i,
    input  ahb_word_t  haddr_i,
    input  wire  [1:0] htrans_i,
    input  wire        hwrite_i,
    input  wire        hready_i,
    input  ahb_word_t  hwdata_i,
    output ahb_word_t  hrdata_o,
    output logic       hreadyout_o,
    output logic       hresp_o,
    input  byte_t      cpu_tdata_i,
    input  wire        cpu_tvalid_i,
    input  wire        cpu_tlast_i,
    output logic       cpu_tready_o,
    output byte_t      mac_tdata_o,
    output logic       mac_tstart_o,
    output logic       mac_tlast_o,
    input  wire        mac_tpnd_i,
    input  byte_t      mac_rdata_i,
    input  wire        mac_rvalid_i,
    input  wire        mac_rlast_i,
    output logic       rx_valid_o,
    output byte_t      rx_data_o,
    output logic       rx_last_o,
    input  wire        rx_credit_i,
    output logic [7:0] rx_drop_count_o,
    output logic       led_o
);

    byte_t udp_tdata;
    logic  udp_tvalid;
    logic  udp_tlast;
    logic  udp_tready;

    heartbeat_led #(
        .HEARTBEAT_TICKS (HEARTBEAT_TICKS)
    ) u_heartbeat_led (
        .HCLK    (HCLK),
        .rst_key (rst_key),
        .led_o   (led_o)
    );

    udp_tx_engine u_udp_tx_engine (
        .HCLK         (HCLK),
        .rst_key      (rst_key),
        .hsel_i       (hsel_i),
        .haddr_i      (haddr_i),
        .htrans_i     (htrans_i),
        .hwrite_i     (hwrite_i),
        .hready_i     (hready_i),
        .hwdata_i     (hwdata_i),
        .hrdata_o     (hrdata_o),
        .hreadyout_o  (hreadyout_o),
        .hresp_o      (hresp_o),
        .udp_tdata_o  (udp_tdata),
        .udp_tvalid_o (udp_tvalid),
        .udp_tlast_o  (udp_tlast),
        .udp_tready_i (udp_tready)
    );

    tx_arbiter u_tx_arbiter (
        .HCLK         (HCLK),
        .rst_key      (rst_key),
        .cpu_tdata_i  (cpu_tdata_i),
        .cpu_tvalid_i (cpu_tvalid_i),
        .cpu_tlast_i  (cpu_tlast_i),
        .cpu_tready_o (cpu_tready_o),
        .udp_tdata_i  (udp_tdata),
        .udp_tvalid_i (udp_tvalid),
        .udp_tlast_i  (udp_tlast),
        .udp_tready_o (udp_tready),
        .mac_tdata_o  (mac_tdata_o),
        .mac_tstart_o (mac_tstart_o),
        .mac_tlast_o  (mac_tlast_o),
        .mac_tpnd_i   (mac_tpnd_i)
    );

    rx_frame_buffer #(
        .RX_DEPTH   (RX_DEPTH),
        .RX_CREDITS (RX_CREDITS)
    ) u_rx_frame_buffer (
        .HCLK            (HCLK),
        .rst_key         (rst_key),
        .mac_rdata_i     (mac_rdata_i),
        .mac_rvalid_i    (mac_rvalid_i),
        .mac_rlast_i     (mac_rlast_i),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o),
        .rx_last_o       (rx_last_o),
        .rx_credit_i     (rx_credit_i),
        .rx_drop_count_o (rx_drop_count_o)
    );

endmodule

`default_nettype wire

// File: verilog/heartbeat_led.sv
`timescale 1ns/1ps
`default_nettype none

module heartbeat_led #(
    parameter logic [26:0] HEARTBEAT_TICKS = 27'd33000000
) (
    input  wire  HCLK,
    input  wire  rst_key,
    output logic led_o
);

    logic [26:0] cnt;
    logic        wrap;

    assign wrap = (cnt >= HEARTBEAT_TICKS);   // period is ticks + 1

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            cnt <= '0;
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 27'd1;
        end
    end

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            led_o <= 1'b1;               // lit out of reset
        end else if (wrap) begin
            led_o <= ~led_o;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rx_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_buffer
    import eth_glue_pkg::*;
#(
    parameter int RX_DEPTH   = 16,   // power of two
    parameter int RX_CREDITS = 4
) (
    input  wire        HCLK,
    input  wire        rst_key,
    input  byte_t      mac_rdata_i,
    input  wire        mac_rvalid_i,
    input  wire        mac_rlast_i,
    output logic       rx_valid_o,
    output byte_t      rx_data_o,
    output logic       rx_last_o,
    input  wire        rx_credit_i,
    output logic [7:0] rx_drop_count_o
);

    localparam int AW = $clog2(RX_DEPTH);
    localparam int CW = $clog2(RX_CREDITS + 1);

    rx_entry_t       mem [RX_DEPTH];
    rx_entry_t       wr_entry;
    rx_entry_t       rd_entry;
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic [CW-1:0]   credits;
    logic            full;
    logic            empty;
    logic            wr_en;
    logic            rd_en;

    assign wr_entry = {mac_rlast_i, mac_rvalid_i, mac_rdata_i};   // same packing as the MAC side
    assign full     = (count == RX_DEPTH[AW:0]);
    assign empty    = (count == '0);
    assign wr_en    = mac_rvalid_i && !full;
    assign rd_en    = !empty && (credits != '0);

    always_ff @(posedge HCLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    assign rd_entry   = mem[rd_ptr];
    assign rx_valid_o = rd_en && rd_entry[8];
    assign rx_data_o  = rd_entry[7:0];
    assign rx_last_o  = rd_entry[9];

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one credit spent per emitted entry, one back per host pulse
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            credits <= CW'(RX_CREDITS);
        end else begin
            case ({rd_en, rx_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            rx_drop_count_o <= '0;
        end else if (mac_rvalid_i && full && rx_drop_count_o != 8'hFF) begin
            rx_drop_count_o <= rx_drop_count_o + 8'd1;   // saturates
        end
    end

endmodule

`default_nettype wire

// File: verilog/tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter
    import eth_glue_pkg::*;
(
    input  wire   HCLK,
    input  wire   rst_key,
    input  byte_t cpu_tdata_i,
    input  wire   cpu_tvalid_i,
    input  wire   cpu_tlast_i,
    output logic  cpu_tready_o,
    input  byte_t udp_tdata_i,
    input  wire   udp_tvalid_i,
    input  wire   udp_tlast_i,
    output logic  udp_tready_o,
    output byte_t mac_tdata_o,
    output logic  mac_tstart_o,
    output logic  mac_tlast_o,
    input  wire   mac_tpnd_i
);

    arb_state_e state;
    logic       first_q;      // next byte opens the frame
    logic       sel_tvalid;
    logic       sel_tlast;
    logic       accept;

    // granted source drives the MAC, the other one is muted
    always_comb begin
        case (state)
            ARB_UDP: begin
                mac_tdata_o = udp_tdata_i;
                sel_tvalid  = udp_tvalid_i;
                sel_tlast   = udp_tlast_i;
            end
            ARB_CPU: begin
                mac_tdata_o = cpu_tdata_i;
                sel_tvalid  = cpu_tvalid_i;
                sel_tlast   = cpu_tlast_i;
            end
            default: begin
                mac_tdata_o = cpu_tdata_i;
                sel_tvalid  = 1'b0;
                sel_tlast   = 1'b0;
            end
        endcase
    end

    assign accept       = sel_tvalid && mac_tpnd_i;
    assign cpu_tready_o = (state == ARB_CPU) && mac_tpnd_i;
    assign udp_tready_o = (state == ARB_UDP) && mac_tpnd_i;
    assign mac_tstart_o = sel_tvalid && first_q;
    assign mac_tlast_o  = sel_tvalid && sel_tlast;

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            state   <= ARB_IDLE;
            first_q <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    first_q <= 1'b1;
                    if (udp_tvalid_i) begin
                        state <= ARB_UDP;      // accelerator has priority
                    end else if (cpu_tvalid_i) begin
                        state <= ARB_CPU;
                    end
                end
                default: begin
                    if (accept) begin
                        first_q <= 1'b0;
                        if (sel_tlast) begin
                            state <= ARB_IDLE; // grant drops after last byte
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/udp_tx_engine.sv
`timescale 1ns/1ps
`default_nettype none

module udp_tx_engine
    import eth_glue_pkg::*;
(
    input  wire        HCLK,
    input  wire        rst_key,
    input  wire        hsel_i,
    input  ahb_word_t  haddr_i,
    input  wire  [1:0] htrans_i,
    input  wire        hwrite_i,
    input  wire        hready_i,
    input  ahb_word_t  hwdata_i,
    output ahb_word_t  hrdata_o,
    output logic       hreadyout_o,
    output logic       hresp_o,
    output byte_t      udp_tdata_o,
    output logic       udp_tvalid_o,
    output logic       udp_tlast_o,
    input  wire        udp_tready_i
);

    udp_state_e  state;
    logic        addr_hit;
    logic        dph_valid;                // data phase pending
    logic        dph_write;
    udp_reg_e    dph_reg;
    frame_len_t  len_q;
    byte_t       seed_q;
    byte_t       cur_byte;
    frame_len_t  remaining;
    logic [15:0] frame_cnt;
    logic        wr_en;
    logic        go;
    logic        accept;

    assign addr_hit = hsel_i && hready_i &&
                      (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ) &&
                      (haddr_i[31:28] == UDP_REGION);

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            dph_valid <= 1'b0;
            dph_write <= 1'b0;
            dph_reg   <= REG_LEN;
        end else begin
            dph_valid <= addr_hit;
            dph_write <= hwrite_i;
            dph_reg   <= udp_reg_e'(haddr_i[3:0]);
        end
    end

    assign wr_en  = dph_valid && dph_write;
    assign go     = wr_en && (dph_reg == REG_CTRL) && hwdata_i[0] &&
                    (state == UDP_IDLE) && (len_q != '0);
    assign accept = udp_tvalid_o && udp_tready_i;

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            len_q  <= '0;
            seed_q <= '0;
        end else if (wr_en) begin
            case (dph_reg)
                REG_LEN:  len_q  <= hwdata_i[10:0];
                REG_SEED: seed_q <= hwdata_i[7:0];
                default:  ;
            endcase
        end
    end

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            state     <= UDP_IDLE;
            cur_byte  <= '0;
            remaining <= '0;
            frame_cnt <= '0;
        end else begin
            case (state)
                UDP_IDLE: begin
                    if (go) begin
                        state     <= UDP_SEND;   // tvalid the cycle after data phase
                        cur_byte  <= seed_q;
                        remaining <= len_q;
                    end
                end
                default: begin
                    if (accept) begin
                        cur_byte  <= cur_byte + 8'd1;   // wraps mod 256
                        remaining <= remaining - 11'd1;
                        if (udp_tlast_o) begin
                            state     <= UDP_IDLE;
                            frame_cnt <= frame_cnt + 16'd1;
                        end
                    end
                end
            endcase
        end
    end

    assign udp_tvalid_o = (state == UDP_SEND);
    assign udp_tdata_o  = cur_byte;
    assign udp_tlast_o  = udp_tvalid_o && (remaining == 11'd1);

    always_comb begin
        hrdata_o = '0;
        if (dph_valid && !dph_write) begin
            case (dph_reg)
                REG_LEN:    hrdata_o = {21'd0, len_q};
                REG_CTRL:   hrdata_o = {31'd0, udp_tvalid_o};
                REG_SEED:   hrdata_o = {24'd0, seed_q};
                REG_STATUS: hrdata_o = {frame_cnt, 15'd0, udp_tvalid_o};
                default:    hrdata_o = '0;
            endcase
        end
    end

    assign hreadyout_o = 1'b1;   // zero wait states
    assign hresp_o     = 1'b0;   // always OKAY

endmodule

`default_nettype wire
